/* design/pisa_pipe_pkg.sv */
// PISA pipeline shared definitions
// Instruction word views, opcode and function fields, control encodings

package pisa_pipe_pkg;

  //------------------------------------------------------------
  // Instruction word, decoded as R, I or J format
  //------------------------------------------------------------

  typedef union packed {
    struct packed {
      logic [5:0] opcode;
      logic [4:0] rs;
      logic [4:0] rt;
      logic [4:0] rd;
      logic [4:0] shamt;
      logic [5:0] func;
    } r_fmt;
    struct packed {
      logic [5:0]  opcode;
      logic [4:0]  rs;
      logic [4:0]  rt;
      logic [15:0] imm;
    } i_fmt;
    struct packed {
      logic [5:0]  opcode;
      logic [25:0] target;
    } j_fmt;
  } pisa_inst_t;

  // Opcodes
  localparam logic [5:0] op_special = 6'h00;
  localparam logic [5:0] op_j       = 6'h02;
  localparam logic [5:0] op_bne     = 6'h05;
  localparam logic [5:0] op_addiu   = 6'h09;
  localparam logic [5:0] op_ori     = 6'h0d;
  localparam logic [5:0] op_lui     = 6'h0f;
  localparam logic [5:0] op_cop0    = 6'h10;
  localparam logic [5:0] op_lw      = 6'h23;

  // Function field of special ops
  localparam logic [5:0] fn_sll  = 6'h00;
  localparam logic [5:0] fn_addu = 6'h21;
  localparam logic [5:0] fn_subu = 6'h23;
  localparam logic [5:0] fn_and  = 6'h24;
  localparam logic [5:0] fn_or   = 6'h25;

  // cop0 ops live in the rs field
  localparam logic [4:0] cop0_mf = 5'h00;
  localparam logic [4:0] cop0_mt = 5'h04;

  //------------------------------------------------------------
  // Control encodings
  //------------------------------------------------------------

  localparam logic [3:0] alu_add    = 4'd0;
  localparam logic [3:0] alu_sub    = 4'd1;
  localparam logic [3:0] alu_and    = 4'd2;
  localparam logic [3:0] alu_or     = 4'd3;
  localparam logic [3:0] alu_sll    = 4'd4;
  localparam logic [3:0] alu_cp_op0 = 4'd5;
  localparam logic [3:0] alu_cp_op1 = 4'd6;

  localparam logic [1:0] pc_plus4  = 2'd0;
  localparam logic [1:0] pc_branch = 2'd1;
  localparam logic [1:0] pc_jump   = 2'd2;
  localparam logic [1:0] pc_hold   = 2'd3;

  localparam logic [1:0] op0_shamt   = 2'd0;
  localparam logic [1:0] op0_rs      = 2'd1;
  localparam logic [1:0] op0_sixteen = 2'd2;

  localparam logic [2:0] op1_rt       = 3'd0;
  localparam logic [2:0] op1_imm_sext = 3'd1;
  localparam logic [2:0] op1_pc_plus4 = 3'd2;
  localparam logic [2:0] op1_imm_zext = 3'd3;
  localparam logic [2:0] op1_mngr     = 3'd4;

endpackage

/* design/pisa_pipe_alu.sv */
// PISA pipeline ALU
// Arithmetic, logic, shift and operand copy, plus equality for bne

module pisa_pipe_alu (
  input  logic [31:0] in0,
  input  logic [31:0] in1,
  input  logic [3:0]  fn,
  output logic [31:0] out,
  output logic        ops_eq
);

  import pisa_pipe_pkg::*;

  always_comb begin
    case (fn)
      alu_add: begin
        out = in0 + in1;
      end
      alu_sub: begin
        out = in0 - in1;
      end
      alu_and: begin
        out = in0 & in1;
      end
      alu_or: begin
        out = in0 | in1;
      end
      // Shift amount comes in on in0
      alu_sll: begin
        out = in1 << in0[4:0];
      end
      alu_cp_op0: begin
        out = in0;
      end
      alu_cp_op1: begin
        out = in1;
      end
      default: begin
        out = 32'd0;
      end
    endcase
  end

  // Branch condition, independent of fn
  assign ops_eq = (in0 == in1);

endmodule

/* design/pisa_pipe_regfile.sv */
// PISA register file
// 32 entries, two combinational reads, one clocked write, r0 reads zero

module pisa_pipe_regfile (
  input  logic        clk,
  input  logic        reset,
  input  logic [4:0]  read_addr0,
  output logic [31:0] read_data0,
  input  logic [4:0]  read_addr1,
  output logic [31:0] read_data1,
  input  logic        write_en,
  input  logic [4:0]  write_addr,
  input  logic [31:0] write_data
);

  logic [31:0] regs [0:31];

  // No writes while the core is in reset, r0 never written
  always_ff @(posedge clk) begin
    if (!reset && write_en && (write_addr != 5'd0)) begin
      regs[write_addr] <= write_data;
    end
  end

  assign read_data0 = (read_addr0 == 5'd0) ? 32'd0 : regs[read_addr0];
  assign read_data1 = (read_addr1 == 5'd0) ? 32'd0 : regs[read_addr1];

endmodule

/* design/pisa_pipe_dpath.sv */
// PISA five-stage pipeline datapath
// PC selection, decode operands, execute, memory and writeback registers

module pisa_pipe_dpath #(
  parameter logic [31:0] reset_vector = 32'h1000
) (
  input  logic                      clk,
  input  logic                      reset,

  // Instruction and data memory
  output logic [31:0]               imem_addr,
  input  logic [31:0]               imem_data,
  output logic [31:0]               dmem_addr,
  input  logic [31:0]               dmem_data,

  // Manager
  input  logic [31:0]               from_mngr_data,
  output logic [31:0]               to_mngr_data,

  // Control from the controller
  input  logic [1:0]                pc_sel_f,
  input  logic                      reg_en_f,
  input  logic                      reg_en_d,
  input  logic                      reg_en_x,
  input  logic                      reg_en_m,
  input  logic                      reg_en_w,
  input  logic [1:0]                op0_sel_d,
  input  logic [2:0]                op1_sel_d,
  input  logic [3:0]                alu_fn_x,
  input  logic                      wb_sel_m,
  input  logic [4:0]                rf_waddr_w,
  input  logic                      rf_wen_w,

  // Status back to the controller
  output pisa_pipe_pkg::pisa_inst_t inst_d,
  output logic                      br_eq_x
);

  import pisa_pipe_pkg::*;

  // sll r0, r0, 0
  localparam logic [31:0] nop_inst = 32'h0000_0000;

  logic [31:0] br_target_x;
  logic [31:0] j_target_d;
  logic [31:0] rf_wdata_w;

  //------------------------------------------------------------
  // F stage
  //------------------------------------------------------------

  logic [31:0] pc_f;
  logic [31:0] pc_plus4_f;
  logic [31:0] pc_next_f;

  // Starts one word early so the first fetch is the reset vector
  always_ff @(posedge clk) begin
    if (reset) begin
      pc_f <= reset_vector - 32'd4;
    end else if (reg_en_f) begin
      pc_f <= pc_next_f;
    end
  end

  assign pc_plus4_f = pc_f + 32'd4;

  always_comb begin
    case (pc_sel_f)
      pc_branch: pc_next_f = br_target_x;
      pc_jump:   pc_next_f = j_target_d;
      pc_hold:   pc_next_f = pc_f;
      default:   pc_next_f = pc_plus4_f;
    endcase
  end

  // Memory answers next cycle, when this address sits in pc_f
  assign imem_addr = pc_next_f;

  //------------------------------------------------------------
  // D stage
  //------------------------------------------------------------

  logic [31:0] pc_plus4_d;
  logic [31:0] imm_sext_d;
  logic [31:0] imm_zext_d;
  logic [31:0] shamt_zext_d;
  logic [31:0] rf_rdata0_d;
  logic [31:0] rf_rdata1_d;
  logic [31:0] op0_d;
  logic [31:0] op1_d;
  logic [31:0] br_target_d;

  always_ff @(posedge clk) begin
    if (reset) begin
      inst_d <= nop_inst;
    end else if (reg_en_d) begin
      inst_d <= imem_data;
    end
  end

  always_ff @(posedge clk) begin
    if (reg_en_d) begin
      pc_plus4_d <= pc_plus4_f;
    end
  end

  assign imm_sext_d   = {{16{inst_d.i_fmt.imm[15]}}, inst_d.i_fmt.imm};
  assign imm_zext_d   = {16'd0, inst_d.i_fmt.imm};
  assign shamt_zext_d = {27'd0, inst_d.r_fmt.shamt};

  pisa_pipe_regfile rfile_i (
    .clk        (clk),
    .reset      (reset),
    .read_addr0 (inst_d.r_fmt.rs),
    .read_data0 (rf_rdata0_d),
    .read_addr1 (inst_d.r_fmt.rt),
    .read_data1 (rf_rdata1_d),
    .write_en   (rf_wen_w),
    .write_addr (rf_waddr_w),
    .write_data (rf_wdata_w)
  );

  always_comb begin
    case (op0_sel_d)
      op0_rs:      op0_d = rf_rdata0_d;
      op0_sixteen: op0_d = 32'd16;
      default:     op0_d = shamt_zext_d;
    endcase
  end

  always_comb begin
    case (op1_sel_d)
      op1_imm_sext: op1_d = imm_sext_d;
      op1_pc_plus4: op1_d = pc_plus4_d;
      op1_imm_zext: op1_d = imm_zext_d;
      op1_mngr:     op1_d = from_mngr_data;
      default:      op1_d = rf_rdata1_d;
    endcase
  end

  // Branch resolves in X, jump goes straight from D
  assign br_target_d = pc_plus4_d + {imm_sext_d[29:0], 2'b00};
  assign j_target_d  = {pc_plus4_d[31:28], inst_d.j_fmt.target, 2'b00};

  //------------------------------------------------------------
  // X stage
  //------------------------------------------------------------

  logic [31:0] op0_x;
  logic [31:0] op1_x;
  logic [31:0] alu_result_x;

  always_ff @(posedge clk) begin
    if (reg_en_x) begin
      op0_x       <= op0_d;
      op1_x       <= op1_d;
      br_target_x <= br_target_d;
    end
  end

  pisa_pipe_alu alu_i (
    .in0    (op0_x),
    .in1    (op1_x),
    .fn     (alu_fn_x),
    .out    (alu_result_x),
    .ops_eq (br_eq_x)
  );

  assign dmem_addr = alu_result_x;

  //------------------------------------------------------------
  // M and W stages
  //------------------------------------------------------------

  logic [31:0] ex_result_m;
  logic [31:0] wb_result_m;
  logic [31:0] wb_result_w;

  always_ff @(posedge clk) begin
    if (reg_en_m) begin
      ex_result_m <= alu_result_x;
    end
  end

  // Load data arrives here
  assign wb_result_m = wb_sel_m ? dmem_data : ex_result_m;

  always_ff @(posedge clk) begin
    if (reg_en_w) begin
      wb_result_w <= wb_result_m;
    end
  end

  assign rf_wdata_w   = wb_result_w;
  assign to_mngr_data = wb_result_w;

  // Every fetch address, including branch and jump targets, is a word
  imem_addr_aligned: assert property (
    @(posedge clk) disable iff (reset) imem_addr[1:0] == 2'b00
  );

endmodule

/* design/pisa_pipe_ctrl.sv */
// PISA five-stage pipeline controller
// Stage valid bits, instruction decode, RAW stalls, squashes, manager strobes

module pisa_pipe_ctrl (
  input  logic                      clk,
  input  logic                      reset,
  input  pisa_pipe_pkg::pisa_inst_t inst_d,
  input  logic                      br_eq_x,

  output logic [1:0]                pc_sel_f,
  output logic                      reg_en_f,
  output logic                      reg_en_d,
  output logic                      reg_en_x,
  output logic                      reg_en_m,
  output logic                      reg_en_w,
  output logic [1:0]                op0_sel_d,
  output logic [2:0]                op1_sel_d,
  output logic [3:0]                alu_fn_x,
  output logic                      wb_sel_m,
  output logic [4:0]                rf_waddr_w,
  output logic                      rf_wen_w,

  output logic                      from_mngr_rd,
  output logic                      to_mngr_val
);

  import pisa_pipe_pkg::*;

  logic       val_f;
  logic       val_d;
  logic       val_x;
  logic       val_m;
  logic       val_w;
  logic       stall_d;
  logic       go_d;
  logic       j_taken_d;
  logic       br_taken_x;

  // Decoded D fields
  logic       rs_en_d;
  logic       rt_en_d;
  logic       wen_d;
  logic [4:0] waddr_d;
  logic [3:0] alu_fn_d;
  logic       wb_sel_d;
  logic       br_d;
  logic       j_d;
  logic       mfc0_d;
  logic       mtc0_d;

  // Fields carried down the pipe
  logic       wen_x;
  logic       wen_m;
  logic       wen_w;
  logic [4:0] waddr_x;
  logic [4:0] waddr_m;
  logic       wb_sel_x;
  logic       br_x;
  logic       mtc0_x;
  logic       mtc0_m;
  logic       mtc0_w;
  logic       raw_x;
  logic       raw_m;
  logic       raw_w;

  //------------------------------------------------------------
  // Decode
  //------------------------------------------------------------

  always_comb begin
    // anything unknown decodes as a nop
    rs_en_d   = 1'b0;
    rt_en_d   = 1'b0;
    wen_d     = 1'b0;
    waddr_d   = inst_d.i_fmt.rt;
    op0_sel_d = op0_rs;
    op1_sel_d = op1_rt;
    alu_fn_d  = alu_add;
    wb_sel_d  = 1'b0;
    br_d      = 1'b0;
    j_d       = 1'b0;
    mfc0_d    = 1'b0;
    mtc0_d    = 1'b0;
    case (inst_d.r_fmt.opcode)
      op_special: begin
        wen_d   = 1'b1;
        rt_en_d = 1'b1;
        rs_en_d = 1'b1;
        waddr_d = inst_d.r_fmt.rd;
        case (inst_d.r_fmt.func)
          fn_addu: alu_fn_d = alu_add;
          fn_subu: alu_fn_d = alu_sub;
          fn_and:  alu_fn_d = alu_and;
          fn_or:   alu_fn_d = alu_or;
          fn_sll: begin
            rs_en_d   = 1'b0;
            op0_sel_d = op0_shamt;
            alu_fn_d  = alu_sll;
          end
          default: begin
            wen_d   = 1'b0;
            rt_en_d = 1'b0;
            rs_en_d = 1'b0;
          end
        endcase
      end
      op_addiu, op_lw: begin
        rs_en_d   = 1'b1;
        wen_d     = 1'b1;
        op1_sel_d = op1_imm_sext;
        wb_sel_d  = (inst_d.i_fmt.opcode == op_lw);
      end
      op_ori: begin
        rs_en_d   = 1'b1;
        wen_d     = 1'b1;
        op1_sel_d = op1_imm_zext;
        alu_fn_d  = alu_or;
      end
      // Immediate shifted up by sixteen
      op_lui: begin
        wen_d     = 1'b1;
        op0_sel_d = op0_sixteen;
        op1_sel_d = op1_imm_zext;
        alu_fn_d  = alu_sll;
      end
      op_bne: begin
        rs_en_d  = 1'b1;
        rt_en_d  = 1'b1;
        br_d     = 1'b1;
        alu_fn_d = alu_sub;
      end
      op_j: j_d = 1'b1;
      op_cop0: begin
        alu_fn_d = alu_cp_op1;
        if (inst_d.r_fmt.rs == cop0_mf) begin
          wen_d     = 1'b1;
          op1_sel_d = op1_mngr;
          mfc0_d    = 1'b1;
        end else if (inst_d.r_fmt.rs == cop0_mt) begin
          rt_en_d = 1'b1;
          mtc0_d  = 1'b1;
        end
      end
      default: ;
    endcase
  end

  //------------------------------------------------------------
  // Hazards and pipeline control
  //------------------------------------------------------------

  // True when a later stage will write a register D still has to read
  function automatic logic raw_hit(
    input logic       val,
    input logic       wen,
    input logic [4:0] waddr,
    input logic       rs_en,
    input logic       rt_en,
    input logic [4:0] rs,
    input logic [4:0] rt
  );
    raw_hit = val && wen && (waddr != 5'd0) &&
              ((rs_en && (waddr == rs)) || (rt_en && (waddr == rt)));
  endfunction

  assign raw_x = raw_hit(val_x, wen_x, waddr_x, rs_en_d, rt_en_d,
                         inst_d.r_fmt.rs, inst_d.r_fmt.rt);
  assign raw_m = raw_hit(val_m, wen_m, waddr_m, rs_en_d, rt_en_d,
                         inst_d.r_fmt.rs, inst_d.r_fmt.rt);
  assign raw_w = raw_hit(val_w, wen_w, rf_waddr_w, rs_en_d, rt_en_d,
                         inst_d.r_fmt.rs, inst_d.r_fmt.rt);

  assign br_taken_x = val_x && br_x && !br_eq_x;
  assign stall_d    = val_d && !br_taken_x && (raw_x || raw_m || raw_w);
  assign j_taken_d  = val_d && j_d && !br_taken_x;
  assign go_d       = val_d && !stall_d && !br_taken_x;

  assign reg_en_f = !stall_d;
  assign reg_en_d = !stall_d;
  assign reg_en_x = 1'b1;
  assign reg_en_m = 1'b1;
  assign reg_en_w = 1'b1;

  // Branch in X wins over everything younger
  always_comb begin
    if (br_taken_x) begin
      pc_sel_f = pc_branch;
    end else if (stall_d) begin
      pc_sel_f = pc_hold;
    end else if (j_taken_d) begin
      pc_sel_f = pc_jump;
    end else begin
      pc_sel_f = pc_plus4;
    end
  end

  //------------------------------------------------------------
  // Stage registers
  //------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      val_f <= 1'b0;
      val_d <= 1'b0;
    end else begin
      // Fetch data is good from the second cycle on
      val_f <= 1'b1;
      if (reg_en_d) begin
        val_d <= val_f && !j_taken_d && !br_taken_x;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      val_x <= 1'b0;
      val_m <= 1'b0;
      val_w <= 1'b0;
      wen_x <= 1'b0;
      wen_m <= 1'b0;
      wen_w <= 1'b0;
      br_x <= 1'b0;
      mtc0_x <= 1'b0;
      mtc0_m <= 1'b0;
      mtc0_w <= 1'b0;
      wb_sel_x <= 1'b0;
      wb_sel_m <= 1'b0;
      alu_fn_x <= alu_add;
      waddr_x <= 5'd0;
      waddr_m <= 5'd0;
      rf_waddr_w <= 5'd0;
    end else begin
      if (reg_en_x) begin
        val_x    <= go_d;
        wen_x    <= wen_d;
        waddr_x  <= waddr_d;
        alu_fn_x <= alu_fn_d;
        wb_sel_x <= wb_sel_d;
        br_x     <= br_d;
        mtc0_x   <= mtc0_d;
      end
      if (reg_en_m) begin
        val_m    <= val_x;
        wen_m    <= wen_x;
        waddr_m  <= waddr_x;
        wb_sel_m <= wb_sel_x;
        mtc0_m   <= mtc0_x;
      end
      if (reg_en_w) begin
        val_w      <= val_m;
        wen_w      <= wen_m;
        rf_waddr_w <= waddr_m;
        mtc0_w     <= mtc0_m;
      end
    end
  end

  assign rf_wen_w     = val_w && wen_w;
  assign to_mngr_val  = val_w && mtc0_w;
  assign from_mngr_rd = go_d && mfc0_d && reg_en_x;

  // A taken branch leaves bubbles in D and X, even if D was stalled
  branch_squash: assert property (
    @(posedge clk) disable iff (reset) br_taken_x |=> !val_d && !val_x
  );

  // An mtc0 leaving W goes to the manager and never to the register file
  mngr_out_no_wb: assert property (
    @(posedge clk) disable iff (reset) to_mngr_val |-> !rf_wen_w
  );

endmodule

/* design/pisa_pipe_top.sv */
// PISA five-stage pipelined core
// Controller and datapath joined by their control and status wires

module pisa_pipe_top #(
  parameter logic [31:0] reset_vector = 32'h1000
) (
  input  logic        clk,
  input  logic        reset,
  output logic [31:0] imem_addr,
  input  logic [31:0] imem_data,
  output logic [31:0] dmem_addr,
  input  logic [31:0] dmem_data,
  input  logic [31:0] from_mngr_data,
  output logic        from_mngr_rd,
  output logic [31:0] to_mngr_data,
  output logic        to_mngr_val
);

  import pisa_pipe_pkg::*;

  pisa_inst_t  inst_d;
  logic        br_eq_x;
  logic [1:0]  pc_sel_f;
  logic        reg_en_f;
  logic        reg_en_d;
  logic        reg_en_x;
  logic        reg_en_m;
  logic        reg_en_w;
  logic [1:0]  op0_sel_d;
  logic [2:0]  op1_sel_d;
  logic [3:0]  alu_fn_x;
  logic        wb_sel_m;
  logic [4:0]  rf_waddr_w;
  logic        rf_wen_w;

  pisa_pipe_ctrl ctrl_i (
    .clk          (clk),
    .reset        (reset),
    .inst_d       (inst_d),
    .br_eq_x      (br_eq_x),
    .pc_sel_f     (pc_sel_f),
    .reg_en_f     (reg_en_f),
    .reg_en_d     (reg_en_d),
    .reg_en_x     (reg_en_x),
    .reg_en_m     (reg_en_m),
    .reg_en_w     (reg_en_w),
    .op0_sel_d    (op0_sel_d),
    .op1_sel_d    (op1_sel_d),
    .alu_fn_x     (alu_fn_x),
    .wb_sel_m     (wb_sel_m),
    .rf_waddr_w   (rf_waddr_w),
    .rf_wen_w     (rf_wen_w),
    .from_mngr_rd (from_mngr_rd),
    .to_mngr_val  (to_mngr_val)
  );

  pisa_pipe_dpath #(
    .reset_vector (reset_vector)
  ) dpath_i (
    .clk            (clk),
    .reset          (reset),
    .imem_addr      (imem_addr),
    .imem_data      (imem_data),
    .dmem_addr      (dmem_addr),
    .dmem_data      (dmem_data),
    .from_mngr_data (from_mngr_data),
    .to_mngr_data   (to_mngr_data),
    .pc_sel_f       (pc_sel_f),
    .reg_en_f       (reg_en_f),
    .reg_en_d       (reg_en_d),
    .reg_en_x       (reg_en_x),
    .reg_en_m       (reg_en_m),
    .reg_en_w       (reg_en_w),
    .op0_sel_d      (op0_sel_d),
    .op1_sel_d      (op1_sel_d),
    .alu_fn_x       (alu_fn_x),
    .wb_sel_m       (wb_sel_m),
    .rf_waddr_w     (rf_waddr_w),
    .rf_wen_w       (rf_wen_w),
    .inst_d         (inst_d),
    .br_eq_x        (br_eq_x)
  );

endmodule

/* verif/pisa_pipe_checker.sv */
// PISA pipeline output checker
// Watches the DUT ports, compares manager output and counts errors

module pisa_pipe_checker #(
  parameter logic [31:0] reset_vector = 32'h1000,
  parameter int          max_words    = 64
) (
  input  logic        clk,
  input  logic        reset,
  input  logic [31:0] imem_addr,
  input  logic        from_mngr_rd,
  input  logic [31:0] to_mngr_data,
  input  logic        to_mngr_val,
  input  logic [31:0] exp_words [0:max_words-1],
  input  int          exp_total,
  output int          seen_count,
  output int          rd_count,
  output int          error_count
);

  int   seen_q = 0;
  int   rd_q = 0;
  int   errors_q = 0;
  logic first_fetch_due = 1'b0;

  assign seen_count  = seen_q;
  assign rd_count    = rd_q;
  assign error_count = errors_q;

  always @(posedge clk) begin : watch
    int edge_errors;
    edge_errors = 0;
    if (reset) begin
      // Strobes stay quiet while the core is held
      if (to_mngr_val) begin
        $display("to_mngr_val went high during reset");
        edge_errors++;
      end
      if (from_mngr_rd) begin
        $display("from_mngr_rd went high during reset");
        edge_errors++;
      end
      first_fetch_due <= 1'b1;
    end else begin
      if (first_fetch_due) begin
        if (imem_addr !== reset_vector) begin
          $display("ERROR imem_addr expected %h actual %h", reset_vector, imem_addr);
          edge_errors++;
        end
        first_fetch_due <= 1'b0;
      end
      if (from_mngr_rd) begin
        rd_q <= rd_q + 1;
      end
      if (to_mngr_val) begin
        if (seen_q >= exp_total) begin
          $display("Unexpected to_mngr_val pulse after all expected values were seen");
          edge_errors++;
        end else begin
          if (to_mngr_data !== exp_words[seen_q]) begin
            $display("ERROR to_mngr_data expected %h actual %h",
                     exp_words[seen_q], to_mngr_data);
            edge_errors++;
          end
          seen_q <= seen_q + 1;
        end
      end
    end
    errors_q <= errors_q + edge_errors;
  end

endmodule

/* verif/pisa_pipe_tb.sv */
// PISA pipeline testbench
// Loads the program and manager values, models both memories, drives the core

module pisa_pipe_tb;

  localparam logic [31:0] reset_vector = 32'h1000;
  localparam int          max_words    = 64;
  localparam int          run_timeout  = 2000;
  localparam int          idle_cycles  = 50;

  logic        clk = 1'b0;
  logic        reset = 1'b1;
  logic [31:0] imem_addr;
  logic [31:0] imem_data = 32'h0;
  logic [31:0] dmem_addr;
  logic [31:0] dmem_data = 32'h0;
  logic [31:0] from_mngr_data = 32'h0;
  logic        from_mngr_rd;
  logic [31:0] to_mngr_data;
  logic        to_mngr_val;

  logic [31:0] prog_words [0:max_words-1];
  logic [31:0] mngr_words [0:max_words-1];
  logic [31:0] exp_words [0:max_words-1];
  int          prog_total = 0;
  int          mngr_total = 0;
  int          exp_total = 0;
  int          mngr_idx = 0;
  int          tb_errors = 0;
  int          seen_count;
  int          rd_count;
  int          error_count;

  pisa_pipe_top #(
    .reset_vector (reset_vector)
  ) pisa_pipe_top_i (
    .clk            (clk),
    .reset          (reset),
    .imem_addr      (imem_addr),
    .imem_data      (imem_data),
    .dmem_addr      (dmem_addr),
    .dmem_data      (dmem_data),
    .from_mngr_data (from_mngr_data),
    .from_mngr_rd   (from_mngr_rd),
    .to_mngr_data   (to_mngr_data),
    .to_mngr_val    (to_mngr_val)
  );

  pisa_pipe_checker #(
    .reset_vector (reset_vector),
    .max_words    (max_words)
  ) pisa_pipe_checker_i (
    .clk          (clk),
    .reset        (reset),
    .imem_addr    (imem_addr),
    .from_mngr_rd (from_mngr_rd),
    .to_mngr_data (to_mngr_data),
    .to_mngr_val  (to_mngr_val),
    .exp_words    (exp_words),
    .exp_total    (exp_total),
    .seen_count   (seen_count),
    .rd_count     (rd_count),
    .error_count  (error_count)
  );

  always #5 clk = ~clk;

  //------------------------------------------------------------
  // Memory and manager models
  //------------------------------------------------------------

  // Words outside the loaded program read as nop
  function automatic logic [31:0] fetch_word(input logic [31:0] addr);
    logic [31:0] offset;
    offset = addr - reset_vector;
    if (addr < reset_vector || (offset >> 2) >= 32'(prog_total)) begin
      return 32'h0;
    end
    return prog_words[offset[7:2]];
  endfunction

  function automatic logic [31:0] mngr_word(input int idx);
    if (idx >= mngr_total) begin
      return 32'h0;
    end
    return mngr_words[idx];
  endfunction

  always @(posedge clk) begin
    imem_data <= fetch_word(imem_addr);
    dmem_data <= dmem_addr ^ 32'h5a5a_0000;
    if (reset) begin
      from_mngr_data <= mngr_word(mngr_idx);
    end else if (from_mngr_rd) begin
      mngr_idx       <= mngr_idx + 1;
      from_mngr_data <= mngr_word(mngr_idx + 1);
    end
  end

  //------------------------------------------------------------
  // Stimulus
  //------------------------------------------------------------

  task automatic load_patterns();
    int          fd;
    int          code;
    string       tag;
    string       rest;
    logic [31:0] word;
    fd = $fopen("verif/pisa_pipe_patterns.txt", "r");
    if (fd == 0) begin
      $display("Could not open the patterns file");
      tb_errors++;
      return;
    end
    while (!$feof(fd)) begin
      code = $fscanf(fd, "%s", tag);
      if (code != 1) begin
        break;
      end
      if (tag == "#") begin
        code = $fgets(rest, fd);
      end else begin
        code = $fscanf(fd, "%h", word);
        if (code != 1) begin
          $display("Malformed line in the patterns file after tag %s", tag);
          tb_errors++;
        end else if (tag == "I" && prog_total < max_words) begin
          prog_words[prog_total] = word;
          prog_total++;
        end else if (tag == "F" && mngr_total < max_words) begin
          mngr_words[mngr_total] = word;
          mngr_total++;
        end else if (tag == "E" && exp_total < max_words) begin
          exp_words[exp_total] = word;
          exp_total++;
        end else begin
          $display("Unknown tag or too many entries in the patterns file: %s", tag);
          tb_errors++;
        end
      end
    end
    $fclose(fd);
  endtask

  task automatic wait_for_outputs();
    int cycles;
    cycles = 0;
    while (seen_count < exp_total && cycles < run_timeout) begin
      @(posedge clk);
      cycles++;
    end
    if (seen_count < exp_total) begin
      $display("Timeout after %0d cycles with %0d of %0d manager outputs seen",
               cycles, seen_count, exp_total);
      tb_errors++;
    end
  endtask

  initial begin
    load_patterns();
    repeat (2) @(posedge clk);
    reset <= 1'b0;
    wait_for_outputs();
    // Self-jump at the end, no more output expected
    repeat (idle_cycles) @(posedge clk);
    if (rd_count != mngr_total) begin
      $display("Saw %0d from_mngr_rd pulses for %0d manager input values",
               rd_count, mngr_total);
      tb_errors++;
    end
    $display("Error count %0d (checker %0d, testbench %0d)",
             error_count + tb_errors, error_count, tb_errors);
    if (error_count + tb_errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

/* verif/pisa_pipe_patterns.txt */
# tag word: I program word from the reset vector up, F manager input value
# E expected manager output, each kind in order
I 24010005
I 34220030
I 3c031234
I 00622021
I 40840000
I 00812823
I 00a23024
I 00063900
I 00e53825
I 40870000
I 40010000
I 40020000
I 40810000
I 00221821
I 40830000
I 8ce40010
I 40840000
I 14210001
I 14220002
I 40850000
I 40860000
I 08000418
I 40850000
I 40860000
I 40840000
I 08000419
F 13579bdf
F 02468ace
E 12340035
E 12340330
E 13579bdf
E 159e26ad
E 486e0340
E 486e0340

/* pisa_pipe.f */
design/pisa_pipe_pkg.sv
design/pisa_pipe_alu.sv
design/pisa_pipe_regfile.sv
design/pisa_pipe_dpath.sv
design/pisa_pipe_ctrl.sv
design/pisa_pipe_top.sv
verif/pisa_pipe_checker.sv
verif/pisa_pipe_tb.sv

/* Makefile */
.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f pisa_pipe.f --top-module pisa_pipe_tb -o sim

run: build
	@out="$$(./obj_dir/sim)"; echo "$$out"; echo "$$out" | grep -qx "All checks passed"

lint:
	verilator --lint-only --timing -f pisa_pipe.f --top-module pisa_pipe_tb

clean:
	rm -rf obj_dir
